// ==== verilog/vlu_isa_pkg.sv ====
/*
 * Instruction-side types of the vector load unit.
 * Only unit-strided and strided loads exist, and elements are 32-bit words.
 */
package vlu_isa_pkg;

    //==================================================
    // Memory operation kind
    //==================================================
    typedef enum logic {
        OP_UNIT_STRIDED = 1'b0, // Elements are ELEM_BYTES apart
        OP_STRIDED      = 1'b1  // Elements are in_stride_i bytes apart
    } mem_op_e;

    //==================================================
    // Element geometry
    //==================================================
    // Byte distance between consecutive unit-strided elements
    localparam int ELEM_BYTES = 4;

endpackage

// ==== verilog/vlu_mem_pkg.sv ====
/*
 * Memory-side defaults and the request ticket layout.
 * The ticket is {row index, lane index}, with the lane index in the low bits.
 */
package vlu_mem_pkg;

    // Defaults taken by the top level
    localparam int DEF_LANES  = 8;
    localparam int DEF_DATA_W = 32;
    localparam int DEF_ADDR_W = 32;
    localparam int DEF_VREG_W = 5;
    localparam int DEF_ROWS   = 2; // Power of two, at least 2

    // Ticket width for a given number of rows and lanes
    function automatic int ticket_w(input int rows, input int lanes);
        return $clog2(rows) + $clog2(lanes);
    endfunction

endpackage

// ==== verilog/vlu_row_if.sv ====
/*
 * Link between the sequencer, one row buffer and the writeback arbiter.
 * start and wb_done are single-cycle pulses.
 */
`timescale 1ns/1ps

interface vlu_row_if #(
    parameter int LANES  = vlu_mem_pkg::DEF_LANES,
    parameter int DATA_W = vlu_mem_pkg::DEF_DATA_W,
    parameter int VREG_W = vlu_mem_pkg::DEF_VREG_W
);

    logic                         start;      // Open the row
    logic [LANES-1:0]             start_mask; // Lanes the row must collect
    logic [VREG_W-1:0]            start_dst;
    logic                         free;
    logic                         full;       // All active lanes served
    logic [LANES-1:0][DATA_W-1:0] data;
    logic [LANES-1:0]             mask;
    logic [VREG_W-1:0]            dst;
    logic                         wb_done;

    modport seq_mp (output start, output start_mask, output start_dst, input free);

    modport row_mp (
        input  start, input start_mask, input start_dst, input wb_done,
        output free, output full, output data, output mask, output dst
    );

    modport wb_mp (input full, input data, input mask, input dst, output wb_done);

endinterface

// ==== verilog/vlu_addr_seq.sv ====
/*
 * One instruction at a time, vl of at most 4*LANES elements, LANES a power of two.
 * Rows are used in index order; wrapping back to row 0 waits until all rows are free.
 */
`timescale 1ns/1ps

module vlu_addr_seq #(
    parameter int LANES    = vlu_mem_pkg::DEF_LANES,
    parameter int ADDR_W   = vlu_mem_pkg::DEF_ADDR_W,
    parameter int VREG_W   = vlu_mem_pkg::DEF_VREG_W,
    parameter int NUM_ROWS = vlu_mem_pkg::DEF_ROWS
) (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    // Instruction
    input  logic                       in_valid_i,
    output logic                       in_ready_o,
    input  vlu_isa_pkg::mem_op_e       in_op_i,
    input  logic [ADDR_W-1:0]          in_base_i,
    input  logic [ADDR_W-1:0]          in_stride_i,
    input  logic [$clog2(LANES)+2:0]   in_vl_i,   // Up to 4 registers of elements
    input  logic [VREG_W-1:0]          in_dst_i,
    // Memory request
    output logic                       req_valid_o,
    input  logic                       req_grant_i,
    output logic [ADDR_W-1:0]          req_addr_o,
    output logic [vlu_mem_pkg::ticket_w(NUM_ROWS, LANES)-1:0] req_ticket_o,
    output logic                       busy_o,
    // Row control
    vlu_row_if.seq_mp                  rows [NUM_ROWS]
);

    import vlu_isa_pkg::*;

    localparam int ROW_BITS  = $clog2(NUM_ROWS);
    localparam int LANE_BITS = $clog2(LANES);
    localparam int VL_W      = $clog2(LANES) + 3;

    logic                 accept;
    logic                 grant;
    logic                 last_lane;
    logic                 start_ok;
    logic                 row_started_r;  // Current row already opened
    logic [ADDR_W-1:0]    addr_r;
    logic [ADDR_W-1:0]    step_r;
    logic [VL_W-1:0]      remain_r;       // Elements not yet granted
    logic [LANE_BITS-1:0] lane_ptr_r;
    logic [ROW_BITS-1:0]  row_ptr_r;
    logic [VREG_W-1:0]    dst_r;
    logic [LANES-1:0]     row_mask;
    logic [NUM_ROWS-1:0]  row_free;
    logic [NUM_ROWS-1:0]  row_start;

    //==================================================
    // Control flow
    //==================================================
    assign busy_o     = (remain_r != '0) | ~&row_free;
    assign in_ready_o = ~busy_o;
    assign accept     = in_valid_i & in_ready_o;

    // Row 0 waits for every row, so writeback by lowest index stays in row order
    assign start_ok = (row_ptr_r == '0) ? &row_free : row_free[row_ptr_r];

    assign req_valid_o  = (remain_r != '0) & (row_started_r | start_ok);
    assign grant        = req_valid_o & req_grant_i;
    assign req_addr_o   = addr_r;
    assign req_ticket_o = {row_ptr_r, lane_ptr_r};

    assign last_lane = (lane_ptr_r == LANE_BITS'(LANES - 1)) | (remain_r == VL_W'(1));

    // Low min(remain, LANES) lanes are active
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            row_mask[i] = (remain_r > VL_W'(i));
        end
    end

    always_comb begin
        row_start = '0;
        if ((remain_r != '0) && !row_started_r && start_ok) begin
            row_start[row_ptr_r] = 1'b1;
        end
    end

    for (genvar g = 0; g < NUM_ROWS; g++) begin : g_row
        assign row_free[g]        = rows[g].free;
        assign rows[g].start      = row_start[g];
        assign rows[g].start_mask = row_mask;
        assign rows[g].start_dst  = dst_r;
    end

    //==================================================
    // Expansion state
    //==================================================
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            remain_r      <= '0;
            lane_ptr_r    <= '0;
            row_ptr_r     <= '0;
            row_started_r <= 1'b0;
            dst_r         <= '0;
        end else if (accept) begin
            remain_r   <= in_vl_i;
            lane_ptr_r <= '0;
            dst_r      <= in_dst_i;
        end else begin
            if (grant) begin
                remain_r   <= remain_r - 1'b1;
                lane_ptr_r <= last_lane ? '0 : lane_ptr_r + 1'b1;
                if (last_lane) begin
                    row_ptr_r <= row_ptr_r + 1'b1; // Wraps modulo NUM_ROWS
                    dst_r     <= dst_r + 1'b1;
                end
            end
            if (grant && last_lane) begin
                row_started_r <= 1'b0;
            end else if (|row_start) begin
                row_started_r <= 1'b1;
            end
        end
    end

    // Address only moves on a grant, so it holds while the request waits
    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_r <= in_base_i;
            step_r <= (in_op_i == OP_UNIT_STRIDED) ? ADDR_W'(ELEM_BYTES) : in_stride_i;
        end else if (grant) begin
            addr_r <= addr_r + step_r;
        end
    end

endmodule

// ==== verilog/vlu_row_buf.sv ====
/*
 * One scratchpad row, selected by the row field of the response ticket.
 * A ticket is assumed to have at most one response outstanding.
 */
`timescale 1ns/1ps

module vlu_row_buf #(
    parameter int LANES    = vlu_mem_pkg::DEF_LANES,
    parameter int DATA_W   = vlu_mem_pkg::DEF_DATA_W,
    parameter int VREG_W   = vlu_mem_pkg::DEF_VREG_W,
    parameter int NUM_ROWS = vlu_mem_pkg::DEF_ROWS,
    parameter int ROW_ID   = 0
) (
    input  logic              clk_i,
    input  logic              rstn_i,
    // Broadcast memory responses
    input  logic              resp_valid_i,
    input  logic [vlu_mem_pkg::ticket_w(NUM_ROWS, LANES)-1:0] resp_ticket_i,
    input  logic [DATA_W-1:0] resp_data_i,
    vlu_row_if.row_mp         row
);

    import vlu_mem_pkg::*;

    localparam int ROW_BITS  = $clog2(NUM_ROWS);
    localparam int LANE_BITS = $clog2(LANES);
    localparam int TICKET_W  = ticket_w(NUM_ROWS, LANES);

    logic                         hit;
    logic [LANE_BITS-1:0]         lane;
    logic [LANES-1:0]             active_r;
    logic [LANES-1:0]             served_r;
    logic [VREG_W-1:0]            dst_r;
    logic [LANES-1:0][DATA_W-1:0] data_r;

    // Ticket decode
    assign lane = resp_ticket_i[LANE_BITS-1:0];
    assign hit  = resp_valid_i && (resp_ticket_i[TICKET_W-1:LANE_BITS] == ROW_BITS'(ROW_ID));

    //==================================================
    // Lane tracking
    //==================================================
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            active_r <= '0;
            served_r <= '0;
            dst_r    <= '0;
        end else if (row.wb_done) begin
            active_r <= '0; // Row is free again
            served_r <= '0;
            dst_r    <= '0;
        end else if (row.start) begin
            active_r <= row.start_mask;
            served_r <= '0;
            dst_r    <= row.start_dst;
        end else if (hit) begin
            served_r[lane] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (hit) begin
            data_r[lane] <= resp_data_i;
        end
    end

    assign row.free = ~|active_r;
    assign row.full = |active_r && (served_r == active_r);
    assign row.data = data_r;
    assign row.mask = active_r;
    assign row.dst  = dst_r;

endmodule

// ==== verilog/vlu_wb_arb.sv ====
/*
 * Fixed priority writeback, lowest row index first. Purely combinational.
 */
`timescale 1ns/1ps

module vlu_wb_arb #(
    parameter int LANES    = vlu_mem_pkg::DEF_LANES,
    parameter int DATA_W   = vlu_mem_pkg::DEF_DATA_W,
    parameter int VREG_W   = vlu_mem_pkg::DEF_VREG_W,
    parameter int NUM_ROWS = vlu_mem_pkg::DEF_ROWS
) (
    vlu_row_if.wb_mp                  rows [NUM_ROWS],
    output logic                      wb_req_o,
    input  logic                      wb_grant_i,
    output logic [LANES-1:0]          wb_en_o,
    output logic [VREG_W-1:0]         wb_reg_o,
    output logic [LANES*DATA_W-1:0]   wb_data_o
);

    localparam int SEL_W = $clog2(NUM_ROWS);

    logic                         hit;
    logic [SEL_W-1:0]             sel;
    logic [NUM_ROWS-1:0]          row_full;
    logic [LANES-1:0][DATA_W-1:0] row_data [NUM_ROWS];
    logic [LANES-1:0]             row_mask [NUM_ROWS];
    logic [VREG_W-1:0]            row_dst  [NUM_ROWS];

    for (genvar g = 0; g < NUM_ROWS; g++) begin : g_row
        assign row_full[g]     = rows[g].full;
        assign row_data[g]     = rows[g].data;
        assign row_mask[g]     = rows[g].mask;
        assign row_dst[g]      = rows[g].dst;
        assign rows[g].wb_done = wb_grant_i & hit & (sel == SEL_W'(g));
    end

    // Scan downwards so the lowest full row is left in sel
    always_comb begin
        hit = 1'b0;
        sel = '0;
        for (int i = NUM_ROWS - 1; i >= 0; i--) begin
            if (row_full[i]) begin
                hit = 1'b1;
                sel = SEL_W'(i);
            end
        end
    end

    assign wb_req_o  = hit;
    assign wb_reg_o  = row_dst[sel];
    assign wb_data_o = row_data[sel];
    assign wb_en_o   = row_mask[sel] & {LANES{wb_grant_i & hit}};

endmodule

// ==== verilog/vlu_top.sv ====
/*
 * Vector load unit, unit-strided and strided loads of 32-bit elements.
 * NUM_ROWS must be a power of two and at least 2; LANES a power of two.
 */
`timescale 1ns/1ps

module vlu_top #(
    parameter int LANES    = vlu_mem_pkg::DEF_LANES,
    parameter int DATA_W   = vlu_mem_pkg::DEF_DATA_W,
    parameter int ADDR_W   = vlu_mem_pkg::DEF_ADDR_W,
    parameter int VREG_W   = vlu_mem_pkg::DEF_VREG_W,
    parameter int NUM_ROWS = vlu_mem_pkg::DEF_ROWS
) (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    //==================================================
    // Instruction
    //==================================================
    input  logic                     in_valid_i,
    output logic                     in_ready_o,
    input  vlu_isa_pkg::mem_op_e     in_op_i,
    input  logic [ADDR_W-1:0]        in_base_i,
    input  logic [ADDR_W-1:0]        in_stride_i,  // Bytes, strided loads only
    input  logic [$clog2(LANES)+2:0] in_vl_i,
    input  logic [VREG_W-1:0]        in_dst_i,
    //==================================================
    // Memory
    //==================================================
    output logic                     req_valid_o,
    input  logic                     req_grant_i,
    output logic [ADDR_W-1:0]        req_addr_o,
    output logic [vlu_mem_pkg::ticket_w(NUM_ROWS, LANES)-1:0] req_ticket_o,
    input  logic                     resp_valid_i,
    input  logic [vlu_mem_pkg::ticket_w(NUM_ROWS, LANES)-1:0] resp_ticket_i,
    input  logic [DATA_W-1:0]        resp_data_i,
    //==================================================
    // Register file writeback
    //==================================================
    output logic                     wb_req_o,
    input  logic                     wb_grant_i,
    output logic [LANES-1:0]         wb_en_o,
    output logic [VREG_W-1:0]        wb_reg_o,
    output logic [LANES*DATA_W-1:0]  wb_data_o,
    output logic                     busy_o
);

    vlu_row_if #(.LANES(LANES), .DATA_W(DATA_W), .VREG_W(VREG_W)) row_if [NUM_ROWS] ();

    vlu_addr_seq #(
        .LANES(LANES), .ADDR_W(ADDR_W), .VREG_W(VREG_W), .NUM_ROWS(NUM_ROWS)
    ) u_seq (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_op_i     (in_op_i),
        .in_base_i   (in_base_i),
        .in_stride_i (in_stride_i),
        .in_vl_i     (in_vl_i),
        .in_dst_i    (in_dst_i),
        .req_valid_o (req_valid_o),
        .req_grant_i (req_grant_i),
        .req_addr_o  (req_addr_o),
        .req_ticket_o(req_ticket_o),
        .busy_o      (busy_o),
        .rows        (row_if)
    );

    // One scratchpad row per row interface
    for (genvar g = 0; g < NUM_ROWS; g++) begin : g_row
        vlu_row_buf #(
            .LANES(LANES), .DATA_W(DATA_W), .VREG_W(VREG_W),
            .NUM_ROWS(NUM_ROWS), .ROW_ID(g)
        ) u_row (
            .clk_i        (clk_i),
            .rstn_i       (rstn_i),
            .resp_valid_i (resp_valid_i),
            .resp_ticket_i(resp_ticket_i),
            .resp_data_i  (resp_data_i),
            .row          (row_if[g])
        );
    end

    vlu_wb_arb #(
        .LANES(LANES), .DATA_W(DATA_W), .VREG_W(VREG_W), .NUM_ROWS(NUM_ROWS)
    ) u_wb (
        .rows      (row_if),
        .wb_req_o  (wb_req_o),
        .wb_grant_i(wb_grant_i),
        .wb_en_o   (wb_en_o),
        .wb_reg_o  (wb_reg_o),
        .wb_data_o (wb_data_o)
    );

endmodule

// ==== test/vlu_mem_model.sv ====
/*
 * Memory model with random grant stalls and responses 1 to 6 cycles late.
 * At most one response per cycle; read data is the address XOR 32'h5a5a0000.
 */
`timescale 1ns/1ps

module vlu_mem_model #(
    parameter int ADDR_W   = 32,
    parameter int DATA_W   = 32,
    parameter int TICKET_W = 4
) (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                req_valid_i,
    output logic                req_grant_o,
    input  logic [ADDR_W-1:0]   req_addr_i,
    input  logic [TICKET_W-1:0] req_ticket_i,
    output logic                resp_valid_o,
    output logic [TICKET_W-1:0] resp_ticket_o,
    output logic [DATA_W-1:0]   resp_data_o
);

    localparam int SLOTS = 1 << TICKET_W; // One slot per ticket

    logic [31:0]       lfsr_state;
    logic              slot_busy [SLOTS];
    int                slot_wait [SLOTS];
    logic [DATA_W-1:0] slot_data [SLOTS];

    // Galois LFSR, taps 32 30 26 25
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v          = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state); // One step per bit
        end
        return v;
    endfunction

    // Lowest ready ticket goes first, the rest keep waiting
    task automatic send_response();
        logic sent;
        sent         = 1'b0;
        resp_valid_o = 1'b0;
        for (int s = 0; s < SLOTS; s++) begin
            if (slot_busy[s] && slot_wait[s] > 0) slot_wait[s]--;
            if (slot_busy[s] && slot_wait[s] == 0 && !sent) begin
                sent          = 1'b1;
                slot_busy[s]  = 1'b0;
                resp_valid_o  = 1'b1;
                resp_ticket_o = TICKET_W'(s);
                resp_data_o   = slot_data[s];
            end
        end
    endtask

    initial begin
        lfsr_state    = 32'ha826;
        req_grant_o   = 1'b0;
        resp_valid_o  = 1'b0;
        resp_ticket_o = '0;
        resp_data_o   = '0;
        for (int s = 0; s < SLOTS; s++) begin
            slot_busy[s] = 1'b0;
            slot_wait[s] = 0;
        end
        forever begin
            @(posedge clk_i);
            if (rstn_i && req_valid_i && req_grant_o) begin
                slot_busy[req_ticket_i] = 1'b1;
                slot_wait[req_ticket_i] = 1 + rand_bits(3) % 6;
                slot_data[req_ticket_i] = DATA_W'(req_addr_i ^ 32'h5a5a_0000);
            end
            #1;
            send_response();
            req_grant_o = rstn_i && (rand_bits(2) != 0); // Stall about one cycle in four
        end
    end

endmodule

// ==== test/tb_vlu.sv ====
/*
 * Testbench of vlu_top at its default parameters, run from the project root.
 * Golden writeback lines carry 8 lanes of data, matching DEF_LANES.
 */
`timescale 1ns/1ps

module tb_vlu;

    import vlu_isa_pkg::*;
    import vlu_mem_pkg::*;

    localparam int LANES    = DEF_LANES;
    localparam int DATA_W   = DEF_DATA_W;
    localparam int ADDR_W   = DEF_ADDR_W;
    localparam int VREG_W   = DEF_VREG_W;
    localparam int NUM_ROWS = DEF_ROWS;
    localparam int TICKET_W = ticket_w(NUM_ROWS, LANES);
    localparam int MAX_E    = 64;
    localparam int TIMEOUT  = 1000; // Cycles allowed per wait

    logic                     clk, rstn, in_valid, in_ready, busy;
    mem_op_e                  in_op;
    logic [ADDR_W-1:0]        in_base, in_stride, req_addr, held_addr;
    logic [$clog2(LANES)+2:0] in_vl;
    logic [VREG_W-1:0]        in_dst, wb_reg;
    logic                     req_valid, req_grant, resp_valid, wb_req, wb_grant;
    logic [TICKET_W-1:0]      req_ticket, resp_ticket, held_ticket;
    logic [DATA_W-1:0]        resp_data;
    logic [LANES-1:0]         wb_en;
    logic [LANES*DATA_W-1:0]  wb_data;

    // Golden file contents
    logic [31:0]             ld_field [MAX_E][5]; // op, base, stride, vl, dst
    int                      ld_wbs   [MAX_E];    // Writebacks per load
    logic [31:0]             exp_reg  [MAX_E];
    logic [31:0]             exp_mask [MAX_E];
    logic [LANES*DATA_W-1:0] exp_data [MAX_E];
    int                      n_loads, n_exp;

    // Scoreboard
    int   errs, errs_mark, n_pass, n_fail;
    int   wb_seen, wb_in_load, wb_load, acc_load, pend_wb;
    logic ready_due, req_waiting;
    logic timed_out;

    vlu_top #(
        .LANES(LANES), .DATA_W(DATA_W), .ADDR_W(ADDR_W), .VREG_W(VREG_W), .NUM_ROWS(NUM_ROWS)
    ) DUT (
        .clk_i(clk), .rstn_i(rstn),
        .in_valid_i(in_valid), .in_ready_o(in_ready), .in_op_i(in_op),
        .in_base_i(in_base), .in_stride_i(in_stride), .in_vl_i(in_vl), .in_dst_i(in_dst),
        .req_valid_o(req_valid), .req_grant_i(req_grant), .req_addr_o(req_addr),
        .req_ticket_o(req_ticket),
        .resp_valid_i(resp_valid), .resp_ticket_i(resp_ticket), .resp_data_i(resp_data),
        .wb_req_o(wb_req), .wb_grant_i(wb_grant), .wb_en_o(wb_en), .wb_reg_o(wb_reg),
        .wb_data_o(wb_data), .busy_o(busy)
    );

    vlu_mem_model #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .TICKET_W(TICKET_W)) u_mem (
        .clk_i(clk), .rstn_i(rstn),
        .req_valid_i(req_valid), .req_grant_o(req_grant), .req_addr_i(req_addr),
        .req_ticket_i(req_ticket),
        .resp_valid_o(resp_valid), .resp_ticket_o(resp_ticket), .resp_data_o(resp_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    task automatic note_timeout(input string why);
        $display("%s", why);
        timed_out = 1'b1;
    endtask

    //==================================================
    // Golden file
    //==================================================
    task automatic load_golden();
        int               fd;
        int               code;
        logic [8*128-1:0] line;
        logic [31:0]      f [10];
        fd = $fopen("test/vlu_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open test/vlu_golden.txt");
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                code = $fgets(line, fd);
                if (code == 0) begin
                    // Nothing read at the end of the file
                end else if ($sscanf(line, "I %h %h %h %h %h",
                                     f[0], f[1], f[2], f[3], f[4]) == 5) begin
                    for (int k = 0; k < 5; k++) ld_field[n_loads][k] = f[k];
                    ld_wbs[n_loads] = 0;
                    n_loads++;
                end else if ($sscanf(line, "E %h %h %h %h %h %h %h %h %h %h", f[0], f[1],
                                     f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]) == 10) begin
                    exp_reg[n_exp]  = f[0];
                    exp_mask[n_exp] = f[1];
                    for (int i = 0; i < LANES; i++) exp_data[n_exp][i*DATA_W +: DATA_W] = f[i+2];
                    ld_wbs[n_loads-1]++; // Belongs to the last load line
                    n_exp++;
                end
            end
            $fclose(fd);
        end
    endtask

    //==================================================
    // Monitor, sampled at the rising edge
    //==================================================
    task automatic check_flow();
        if (pend_wb != 0) begin
            assert (!in_ready) else begin
                $display("** Error: in_ready_o = %h, expected 0 with %0d writebacks pending",
                         in_ready, pend_wb);
                errs++;
            end
            assert (busy) else begin
                $display("** Error: busy_o = %h, expected 1", busy);
                errs++;
            end
        end
        if (ready_due) begin
            assert (in_ready) else begin
                $display("** Error: in_ready_o = %h, expected 1 after the last writeback",
                         in_ready);
                errs++;
            end
            assert (!busy) else begin
                $display("** Error: busy_o = %h, expected 0 after the last writeback", busy);
                errs++;
            end
        end
        if (req_waiting) begin
            assert (req_valid && req_addr == held_addr && req_ticket == held_ticket) else begin
                $display("** Error: req_addr_o = %h req_ticket_o = %h while waiting, expected %h %h",
                         req_addr, req_ticket, held_addr, held_ticket);
                errs++;
            end
        end
        ready_due   = 1'b0;
        req_waiting = req_valid && !req_grant; // Request must hold until granted
        held_addr   = req_addr;
        held_ticket = req_ticket;
    endtask

    task automatic check_writeback();
        logic [DATA_W-1:0] got;
        logic [DATA_W-1:0] want;
        if (wb_seen >= n_exp) begin
            $display("Writeback to register %0d that the golden file does not expect", wb_reg);
            errs++;
        end else begin
            assert (wb_reg == VREG_W'(exp_reg[wb_seen])) else begin
                $display("** Error: wb_reg_o = %h, expected %h", wb_reg, exp_reg[wb_seen]);
                errs++;
            end
            assert (wb_en == LANES'(exp_mask[wb_seen])) else begin
                $display("** Error: wb_en_o = %h, expected %h", wb_en, exp_mask[wb_seen]);
                errs++;
            end
            for (int i = 0; i < LANES; i++) begin
                got  = wb_data[i*DATA_W +: DATA_W];
                want = exp_data[wb_seen][i*DATA_W +: DATA_W];
                if (exp_mask[wb_seen][i]) begin
                    assert (got == want) else begin
                        $display("** Error: wb_data_o lane %0d = %h, expected %h", i, got, want);
                        errs++;
                    end
                end
            end
            wb_seen++;
            wb_in_load++;
            pend_wb--;
            ready_due = (pend_wb == 0);
            if (wb_in_load == ld_wbs[wb_load]) report_load();
        end
    endtask

    task automatic report_load();
        if (errs == errs_mark) n_pass++;
        else n_fail++;
        $display("Load %0d (v%0d, %0d writebacks): %s", wb_load, ld_field[wb_load][4],
                 ld_wbs[wb_load], (errs == errs_mark) ? "PASS" : "FAIL");
        errs_mark  = errs;
        wb_load++;
        wb_in_load = 0;
    endtask

    always @(posedge clk) begin
        if (rstn) begin
            check_flow();
            if (wb_req && wb_grant) check_writeback();
            if (in_valid && in_ready && acc_load < n_loads) begin
                pend_wb = pend_wb + ld_wbs[acc_load];
                acc_load++;
            end
        end
    end

    //==================================================
    // Stimulus
    //==================================================
    task automatic wait_accept();
        int waited;
        waited = 0;
        @(posedge clk);
        while (!in_ready && waited < TIMEOUT) begin
            waited++;
            @(posedge clk);
        end
        if (!in_ready) note_timeout("Timeout: the load instruction was never accepted");
        else #1;
    endtask

    task automatic wait_writebacks();
        int waited;
        waited = 0;
        while (wb_seen < n_exp && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (wb_seen < n_exp) note_timeout("Timeout: not all expected writebacks arrived");
    endtask

    initial begin
        rstn        = 1'b0;
        in_valid    = 1'b0;
        in_op       = OP_UNIT_STRIDED;
        in_base     = '0;
        in_stride   = '0;
        in_vl       = '0;
        in_dst      = '0;
        wb_grant    = 1'b1;
        ready_due   = 1'b0;
        req_waiting = 1'b0;
        held_addr   = '0;
        held_ticket = '0;
        timed_out   = 1'b0;
        load_golden();
        repeat (2) @(posedge clk);
        #1 rstn = 1'b1;
        @(posedge clk);
        assert (in_ready && !req_valid && !wb_req && !busy) else begin
            $display("** Error: after reset in_ready_o=%h req_valid_o=%h wb_req_o=%h busy_o=%h",
                     in_ready, req_valid, wb_req, busy);
            errs++;
        end
        #1;
        // Next load is presented right after acceptance, so it waits on in_ready_o
        for (int t = 0; t < n_loads && !timed_out; t++) begin
            in_valid  = 1'b1;
            in_op     = mem_op_e'(ld_field[t][0][0]);
            in_base   = ld_field[t][1];
            in_stride = ld_field[t][2];
            in_vl     = ld_field[t][3][$clog2(LANES)+2:0];
            in_dst    = ld_field[t][4][VREG_W-1:0];
            wait_accept();
        end
        in_valid = 1'b0;
        if (!timed_out) wait_writebacks();
        @(posedge clk);
        #1;
        $display("Loads: %0d passed, %0d failed, %0d errors", n_pass, n_fail, errs);
        if (errs == 0 && !timed_out && n_loads > 0 && n_fail == 0 && n_pass == n_loads) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== test/vlu_golden.txt ====
# I op base stride vl dst        op 0 unit-strided, 1 strided, all fields hex
# E reg mask lane0 .. lane7      lane data is the element address XOR 5a5a0000
I 0 00001000 00000100 08 02
E 02 ff 5a5a1000 5a5a1004 5a5a1008 5a5a100c 5a5a1010 5a5a1014 5a5a1018 5a5a101c
I 1 00002000 00000010 05 07
E 07 1f 5a5a2000 5a5a2010 5a5a2020 5a5a2030 5a5a2040 00000000 00000000 00000000
I 0 00003000 00000000 13 0a
E 0a ff 5a5a3000 5a5a3004 5a5a3008 5a5a300c 5a5a3010 5a5a3014 5a5a3018 5a5a301c
E 0b ff 5a5a3020 5a5a3024 5a5a3028 5a5a302c 5a5a3030 5a5a3034 5a5a3038 5a5a303c
E 0c 07 5a5a3040 5a5a3044 5a5a3048 00000000 00000000 00000000 00000000 00000000
I 1 00004000 00000008 03 14
E 14 07 5a5a4000 5a5a4008 5a5a4010 00000000 00000000 00000000 00000000 00000000
I 1 00008000 00000040 0a 04
E 04 ff 5a5a8000 5a5a8040 5a5a8080 5a5a80c0 5a5a8100 5a5a8140 5a5a8180 5a5a81c0
E 05 03 5a5a8200 5a5a8240 00000000 00000000 00000000 00000000 00000000 00000000

// ==== tb.f ====
verilog/vlu_isa_pkg.sv
verilog/vlu_mem_pkg.sv
verilog/vlu_row_if.sv
verilog/vlu_addr_seq.sv
verilog/vlu_row_buf.sv
verilog/vlu_wb_arb.sv
verilog/vlu_top.sv
test/vlu_mem_model.sv
test/tb_vlu.sv

// ==== Makefile ====
# Verilator build and run of the vector load unit testbench
VERILATOR ?= verilator
TOP       ?= tb_vlu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
